/* source/stm_pkg.sv */
`default_nettype none

package stm_pkg;

  localparam int num_segment = 2;

  localparam int cycle_width = 13;
  localparam int div_width = 16;
  localparam int dividend_width = 48;
  localparam int time_width = 64;

  // one input register plus one register per quotient bit.
  localparam int div_latency = dividend_width + 1;
  localparam int pipe_latency = 2 * div_latency + 1;
  localparam int total_latency = pipe_latency + 2;
  localparam int cnt_width = $clog2(total_latency + 1);

  localparam int apb_addr_width = 8;
  localparam logic [apb_addr_width-1:0] addr_ctrl = 8'h00;
  localparam logic [apb_addr_width-1:0] addr_seg_base = 8'h10;
  localparam int seg_stride = 8;
  localparam int seg_cycle_offset = 0;
  localparam int seg_div_offset = 4;
  localparam logic [apb_addr_width-1:0] addr_idx_base = 8'h40;
  localparam int idx_stride = 4;

endpackage

`default_nettype wire

/* source/stm_div.sv */
`timescale 1ns/100ps
`default_nettype none

module stm_div import stm_pkg::*; (
  input  wire logic                      CLK,
  input  wire logic [dividend_width-1:0] dividend,
  input  wire logic [div_width-1:0]      divisor,
  output logic      [dividend_width-1:0] quotient,
  output logic      [div_width-1:0]      remainder
);

  // index 0 is the input register, index s+1 holds the state after stage s.
  logic [div_width-1:0]      rem_q[dividend_width+1];
  logic [dividend_width-1:0] dvd_q[dividend_width+1];
  logic [div_width-1:0]      dsr_q[dividend_width+1];
  logic [dividend_width-1:0] quo_q[dividend_width+1];

  logic [div_width:0] trial[dividend_width];
  logic [div_width:0] diff[dividend_width];
  logic               fit[dividend_width];

  // each stage shifts in the next dividend bit and tries one subtraction.
  // the divisor fits when trial overflows the remainder width or diff does not borrow.
  always_comb begin
    for (int s = 0; s < dividend_width; s++) begin
      trial[s] = {rem_q[s], dvd_q[s][dividend_width-1]};
      diff[s] = trial[s] - {1'b0, dsr_q[s]};
      fit[s] = trial[s][div_width] || !diff[s][div_width];
    end
  end

  always_ff @(posedge CLK) begin
    rem_q[0] <= '0;
    dvd_q[0] <= dividend;
    dsr_q[0] <= divisor;
    quo_q[0] <= '0;
    for (int s = 0; s < dividend_width; s++) begin
      if (fit[s]) begin
        rem_q[s+1] <= diff[s][div_width-1:0];
      end else begin
        rem_q[s+1] <= trial[s][div_width-1:0];
      end
      dvd_q[s+1] <= {dvd_q[s][dividend_width-2:0], 1'b0};
      dsr_q[s+1] <= dsr_q[s];
      quo_q[s+1] <= {quo_q[s][dividend_width-2:0], fit[s]};
    end
  end

  // a zero divisor always fits, so the quotient comes out all ones.
  assign quotient = quo_q[dividend_width];
  assign remainder = rem_q[dividend_width];

endmodule

`default_nettype wire

/* source/stm_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module stm_timer import stm_pkg::*; (
  input  wire logic                   CLK,
  input  wire logic                   rst_n,
  input  wire logic                   update_req,
  input  wire logic [time_width-1:0]  sys_time,
  input  wire logic [cycle_width-1:0] cycle[num_segment],
  input  wire logic [div_width-1:0]   freq_div[num_segment],
  output logic      [cycle_width-1:0] idx[num_segment],
  output logic                        update_done
);

  typedef enum logic {
    st_idle,
    st_load
  } state_t;

  state_t               state;
  logic [cnt_width-1:0] cnt;
  logic                 latch_en;

  assign latch_en = (state == st_idle) && update_req;

  for (genvar i = 0; i < num_segment; i++) begin : gen_seg
    logic [div_width-1:0]      freq_div_q;
    logic [cycle_width:0]      modulus_q;
    logic [dividend_width-1:0] count_quo;
    logic [div_width-1:0]      idx_rem;
    logic [cycle_width-1:0]    idx_q;

    // the modulus is kept as cycle plus one, so it needs one extra bit.
    always_ff @(posedge CLK) begin
      if (!rst_n) begin
        freq_div_q <= div_width'(1);
        modulus_q <= (cycle_width + 1)'(1);
      end else if (latch_en) begin
        freq_div_q <= freq_div[i];
        modulus_q <= (cycle_width + 1)'(cycle[i]) + 1'b1;
      end
    end

    // bits 55 down to 8 of the system time.
    stm_div u_div_count (
      .CLK       (CLK),
      .dividend  (sys_time[8 +: dividend_width]),
      .divisor   (freq_div_q),
      .quotient  (count_quo),
      .remainder ()
    );

    stm_div u_div_idx (
      .CLK       (CLK),
      .dividend  (count_quo),
      .divisor   (div_width'(modulus_q)),
      .quotient  (),
      .remainder (idx_rem)
    );

    always_ff @(posedge CLK) begin
      idx_q <= idx_rem[cycle_width-1:0];
    end

    assign idx[i] = idx_q;
  end

  // wait for the pipeline to run through with the new settings.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state <= st_idle;
      cnt <= '0;
      update_done <= 1'b0;
    end else begin
      update_done <= 1'b0;
      case (state)
        st_idle: begin
          cnt <= '0;
          if (update_req) begin
            state <= st_load;
          end
        end
        st_load: begin
          cnt <= cnt + 1'b1;
          if (cnt == cnt_width'(total_latency - 1)) begin
            update_done <= 1'b1;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/stm_config.sv */
`timescale 1ns/100ps
`default_nettype none

module stm_config import stm_pkg::*; (
  input  wire logic                      CLK,
  input  wire logic                      rst_n,
  input  wire logic                      psel,
  input  wire logic                      penable,
  input  wire logic                      pwrite,
  input  wire logic [apb_addr_width-1:0] paddr,
  input  wire logic [31:0]               pwdata,
  input  wire logic [cycle_width-1:0]    idx[num_segment],
  input  wire logic                      update_done,
  output logic      [31:0]               prdata,
  output logic                           pready,
  output logic                           pslverr,
  output logic      [cycle_width-1:0]    cycle[num_segment],
  output logic      [div_width-1:0]      freq_div[num_segment],
  output logic                           update_req
);

  logic                   busy;
  logic                   access;
  logic                   wr_access;
  logic                   ctrl_hit;
  logic [num_segment-1:0] cycle_hit;
  logic [num_segment-1:0] div_hit;
  logic [num_segment-1:0] idx_hit;
  logic                   mapped;
  logic                   bad_write;
  logic                   req_accept;

  assign access = psel && penable;
  assign wr_access = access && pwrite;

  always_comb begin
    ctrl_hit = (paddr == addr_ctrl);
    for (int i = 0; i < num_segment; i++) begin
      cycle_hit[i] = (paddr == apb_addr_width'(addr_seg_base + i * seg_stride
                                                + seg_cycle_offset));
      div_hit[i] = (paddr == apb_addr_width'(addr_seg_base + i * seg_stride
                                              + seg_div_offset));
      idx_hit[i] = (paddr == apb_addr_width'(addr_idx_base + i * idx_stride));
    end
  end

  assign mapped = ctrl_hit || (|cycle_hit) || (|div_hit) || (|idx_hit);

  // index registers are read only, and ctrl cannot be written during an update.
  assign bad_write = pwrite && ((|idx_hit) || (ctrl_hit && busy));
  assign pslverr = access && (!mapped || bad_write);
  assign pready = 1'b1;

  assign req_accept = wr_access && ctrl_hit && !busy && pwdata[0];

  always_comb begin
    prdata = '0;
    if (ctrl_hit) begin
      prdata = {31'b0, busy};
    end
    for (int i = 0; i < num_segment; i++) begin
      if (cycle_hit[i]) begin
        prdata = 32'(cycle[i]);
      end
      if (div_hit[i]) begin
        prdata = 32'(freq_div[i]);
      end
      if (idx_hit[i]) begin
        prdata = 32'(idx[i]);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 0; i < num_segment; i++) begin
        cycle[i] <= '0;
        freq_div[i] <= div_width'(1);
      end
    end else if (wr_access) begin
      for (int i = 0; i < num_segment; i++) begin
        if (cycle_hit[i]) begin
          cycle[i] <= pwdata[cycle_width-1:0];
        end
        if (div_hit[i]) begin
          freq_div[i] <= pwdata[div_width-1:0];
        end
      end
    end
  end

  // busy covers the whole update, from the request to the done pulse.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      busy <= 1'b0;
      update_req <= 1'b0;
    end else begin
      update_req <= req_accept;
      if (req_accept) begin
        busy <= 1'b1;
      end else if (update_done) begin
        busy <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* source/stm_top.sv */
`timescale 1ns/100ps
`default_nettype none

module stm_top import stm_pkg::*; (
  input  wire logic                      CLK,
  input  wire logic                      rst_n,
  input  wire logic                      psel,
  input  wire logic                      penable,
  input  wire logic                      pwrite,
  input  wire logic [apb_addr_width-1:0] paddr,
  input  wire logic [31:0]               pwdata,
  output logic      [31:0]               prdata,
  output logic                           pready,
  output logic                           pslverr,
  input  wire logic [time_width-1:0]     sys_time,
  output logic      [cycle_width-1:0]    idx[num_segment],
  output logic                           update_done
);

  logic                   update_req;
  logic [cycle_width-1:0] cycle[num_segment];
  logic [div_width-1:0]   freq_div[num_segment];

  stm_config u_config (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .idx         (idx),
    .update_done (update_done),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .cycle       (cycle),
    .freq_div    (freq_div),
    .update_req  (update_req)
  );

  // the timer takes system time directly, there is no local time base.
  stm_timer u_timer (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .update_req  (update_req),
    .sys_time    (sys_time),
    .cycle       (cycle),
    .freq_div    (freq_div),
    .idx         (idx),
    .update_done (update_done)
  );

endmodule

`default_nettype wire

/* tests/stm_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module stm_checker import stm_pkg::*; (
  input wire logic CLK,
  input wire logic rst_n,
  input wire logic latch_en,
  input wire logic update_done
);

  int failures = 0;

  done_one_cycle: assert property (@(posedge CLK) disable iff (!rst_n)
    update_done |=> !update_done)
    else begin
      failures++;
      $error("update_done stayed high for more than one cycle");
    end

  // the done pulse comes a fixed time after the settings are latched.
  done_after_latch: assert property (@(posedge CLK) disable iff (!rst_n)
    latch_en |=> ##total_latency update_done)
    else begin
      failures++;
      $error("update_done did not follow the settings latch in time");
    end

  quiet_after_reset: assert property (@(posedge CLK) !rst_n |=> !update_done)
    else begin
      failures++;
      $error("update_done was high right after reset");
    end

endmodule

bind stm_timer stm_checker u_checker (
  .CLK         (CLK),
  .rst_n       (rst_n),
  .latch_en    (latch_en),
  .update_done (update_done)
);

`default_nettype wire

/* tests/stm_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module stm_tb import stm_pkg::*; ();

  localparam int num_rounds = 8;
  localparam int check_cycles = 64;
  localparam int cycle_limit = num_rounds * (total_latency + 200);

  logic                      CLK;
  logic                      rst_n, psel, penable, pwrite, pready, pslverr, update_done;
  logic [apb_addr_width-1:0] paddr;
  logic [31:0]               pwdata, prdata;
  logic [time_width-1:0]     sys_time;
  logic [cycle_width-1:0]    idx[num_segment];

  logic [time_width-1:0]  hist[cycle_limit+1];
  logic [cycle_width-1:0] idx_snap[num_segment];
  logic [cycle_width-1:0] act_cycle[num_segment];
  logic [div_width-1:0]   act_div[num_segment];
  logic [31:0]            set_rng, time_rng;
  logic                   check_on;
  int                     cyc, done_count, checks, errors;

  stm_top uut (.*);

  always #5 CLK = ~CLK;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // bits 55 down to 8 divided by the divisor, then taken modulo cycle plus one.
  function automatic logic [cycle_width-1:0] expected_index(input logic [time_width-1:0] t,
      input logic [div_width-1:0] div, input logic [cycle_width-1:0] period);
    logic [63:0] count;
    count = 64'(t[55:8]) / 64'(div);
    return cycle_width'(count % (64'(period) + 64'd1));
  endfunction

  function automatic logic [apb_addr_width-1:0] seg_addr(input int i, input int offset);
    return apb_addr_width'(addr_seg_base + i * seg_stride + offset);
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks = checks + 1;
    assert (got === exp) else begin
      errors = errors + 1;
      $display("[FAIL] %0t: %s got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // one setup cycle and one access cycle, sampled while the access phase is stable.
  task automatic apb_transfer(input logic write, input logic [apb_addr_width-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    @(posedge CLK);
    #1;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(posedge CLK);
    #1;
    penable = 1'b1;
    #1;
    rdata = prdata;
    err = pslverr;
    idx_snap = idx;
    check_value(32'(pready), 32'd1, "pready");
    @(posedge CLK);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  // for a read, data is the value expected back.
  task automatic access_check(input logic write, input logic [apb_addr_width-1:0] addr,
                              input logic [31:0] data, input logic exp_err, input string what);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(write, addr, data, rdata, err);
    check_value(32'(err), 32'(exp_err), {what, " pslverr"});
    if (!write && !exp_err) begin
      check_value(rdata, data, what);
    end
  endtask

  // sys_time moves on a little after every edge, and idx trails it by pipe_latency cycles.
  always @(posedge CLK) begin
    cyc = cyc + 1;
    #1;
    if (update_done) begin
      done_count = done_count + 1;
      check_on = 1'b1;
    end
    if (check_on) begin
      for (int i = 0; i < num_segment; i++) begin
        check_value(32'(idx[i]), 32'(expected_index(hist[cyc - pipe_latency], act_div[i],
                    act_cycle[i])), $sformatf("idx[%0d] port", i));
      end
    end
    time_rng = xorshift(time_rng);
    sys_time = sys_time + time_width'(time_rng % 1024) + 1'b1;
    hist[cyc] = sys_time;
  end

  initial begin
    wait (cyc >= cycle_limit);
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Test failures found");
    $finish;
  end

  initial begin
    logic [31:0] rdata;
    logic        err;
    int          done_seen;
    CLK = 1'b0;
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    set_rng = 32'h285c;
    time_rng = xorshift(32'h285c);
    sys_time = {time_rng, xorshift(time_rng)};
    hist[0] = sys_time;
    check_on = 1'b0;
    cyc = 0;
    done_count = 0;
    checks = 0;
    errors = 0;
    repeat (16) @(posedge CLK);
    #1;
    rst_n = 1'b1;

    access_check(1'b0, addr_ctrl, 32'd0, 1'b0, "busy after reset");
    for (int i = 0; i < num_segment; i++) begin
      access_check(1'b0, seg_addr(i, seg_cycle_offset), 32'd0, 1'b0, "cycle reset value");
      access_check(1'b0, seg_addr(i, seg_div_offset), 32'd1, 1'b0, "freq_div reset value");
    end
    access_check(1'b1, 8'h08, 32'h1234, 1'b1, "unmapped write");
    access_check(1'b0, 8'h80, 32'h0, 1'b1, "unmapped read");
    access_check(1'b1, addr_idx_base, 32'h1, 1'b1, "index register write");

    for (int r = 0; r < num_rounds; r++) begin
      check_on = 1'b0;
      for (int i = 0; i < num_segment; i++) begin
        set_rng = xorshift(set_rng);
        act_div[i] = div_width'(set_rng % 65535) + 1'b1;
        set_rng = xorshift(set_rng);
        act_cycle[i] = cycle_width'(set_rng % 8192);
        // the first two rounds put one segment at each extreme.
        if (r < 2) begin
          act_div[i] = (i == r) ? div_width'(1) : {div_width{1'b1}};
          act_cycle[i] = (i == r) ? {cycle_width{1'b1}} : cycle_width'(0);
        end
        access_check(1'b1, seg_addr(i, seg_cycle_offset), 32'(act_cycle[i]), 1'b0,
                     "cycle write");
        access_check(1'b1, seg_addr(i, seg_div_offset), 32'(act_div[i]), 1'b0,
                     "freq_div write");
        access_check(1'b0, seg_addr(i, seg_cycle_offset), 32'(act_cycle[i]), 1'b0,
                     "cycle readback");
        access_check(1'b0, seg_addr(i, seg_div_offset), 32'(act_div[i]), 1'b0,
                     "freq_div readback");
      end
      done_seen = done_count;
      access_check(1'b1, addr_ctrl, 32'd1, 1'b0, "update request");
      access_check(1'b0, addr_ctrl, 32'd1, 1'b0, "busy during update");
      access_check(1'b1, addr_ctrl, 32'd1, 1'b1, "request while busy");
      do begin
        @(posedge CLK);
        #2;
      end while (done_count == done_seen);
      access_check(1'b0, addr_ctrl, 32'd0, 1'b0, "busy after update");
      repeat (check_cycles) @(posedge CLK);
      for (int i = 0; i < num_segment; i++) begin
        apb_transfer(1'b0, apb_addr_width'(addr_idx_base + i * idx_stride), 32'd0, rdata, err);
        check_value(32'(err), 32'd0, "index read pslverr");
        check_value(rdata, 32'(idx_snap[i]), "index readback");
      end
      check_value(done_count, done_seen + 1, "update_done pulse count");
    end

    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             uut.u_timer.u_checker.failures);
    if (errors == 0 && uut.u_timer.u_checker.failures == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
source/stm_pkg.sv
source/stm_div.sv
source/stm_timer.sv
source/stm_config.sv
source/stm_top.sv
tests/stm_checker.sv
tests/stm_tb.sv
